/* core_pkg.sv */
package core_pkg;

	localparam int xlen = 64;
	localparam int ilen = 32;
	localparam int reg_addr_w = 5;

	localparam logic [xlen-1:0] reset_pc = 64'h0;

	// major opcodes
	localparam logic [6:0] op_rtype  = 7'b0110011;
	localparam logic [6:0] op_itype  = 7'b0010011;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;

	localparam logic [2:0] f3_add   = 3'b000;   // add, sub, addi
	localparam logic [2:0] f3_xor   = 3'b100;
	localparam logic [2:0] f3_or    = 3'b110;
	localparam logic [2:0] f3_and   = 3'b111;
	localparam logic [2:0] f3_dword = 3'b011;   // ld, sd
	localparam logic [2:0] f3_beq   = 3'b000;
	localparam logic [2:0] f3_bne   = 3'b001;

	localparam logic [6:0] funct7_base = 7'b0000000;
	localparam logic [6:0] funct7_sub  = 7'b0100000;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_pass_b   // lui
	} alu_op_t;

	// addi x0, x0, 0
	localparam logic [ilen-1:0] nop_instr = 32'h0000_0013;

endpackage

/* regfile.sv */
module regfile (
	input  logic clk,
	input  logic reset,
	input  logic [core_pkg::reg_addr_w-1:0] rs1_addr,
	input  logic [core_pkg::reg_addr_w-1:0] rs2_addr,
	input  logic wen,
	input  logic [core_pkg::reg_addr_w-1:0] wa,
	input  logic [core_pkg::xlen-1:0] wd,
	output logic [core_pkg::xlen-1:0] rs1_data,
	output logic [core_pkg::xlen-1:0] rs2_data
);
	import core_pkg::*;

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wen && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// writeback in the same cycle wins over the stored value
	assign rs1_data = (rs1_addr == '0) ? '0 : ((wen && wa == rs1_addr) ? wd : regs[rs1_addr]);
	assign rs2_data = (rs2_addr == '0) ? '0 : ((wen && wa == rs2_addr) ? wd : regs[rs2_addr]);

endmodule

/* fetch_stage.sv */
module fetch_stage (
	input  logic clk,
	input  logic reset,
	input  logic stall,
	input  logic flush,
	input  logic redirect,
	input  logic [core_pkg::xlen-1:0] redirect_pc,
	input  logic iresp_data_ok,
	input  logic [core_pkg::ilen-1:0] iresp_data,
	output logic ireq_valid,
	output logic [core_pkg::xlen-1:0] ireq_addr,
	output logic fetch_busy,
	output logic if_valid,
	output logic [core_pkg::xlen-1:0] if_pc,
	output logic [core_pkg::ilen-1:0] if_instr
);
	import core_pkg::*;

	logic [xlen-1:0] pc, pc_next;
	logic [ilen-1:0] buf_instr, cur_instr;
	logic buf_valid, buf_valid_next;
	logic drop;
	logic advance, req_done, req_wait, resp_good, word_ready;

	assign advance = ~stall;
	assign req_done = ireq_valid & iresp_data_ok;
	assign req_wait = ireq_valid & ~iresp_data_ok;
	assign resp_good = req_done & ~drop;   // stale words never reach IF/ID
	assign word_ready = buf_valid | resp_good;
	assign cur_instr = buf_valid ? buf_instr : iresp_data;
	assign fetch_busy = ~word_ready & ~redirect;   // a redirect bubbles IF/ID anyway

	assign pc_next = ~advance ? pc : (redirect ? redirect_pc : pc + 4);
	assign buf_valid_next = advance ? 1'b0 : (buf_valid | resp_good);

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= reset_pc;
			buf_valid <= 1'b0;
			drop <= 1'b0;
			ireq_valid <= 1'b0;
			ireq_addr <= reset_pc;
		end else begin
			pc <= pc_next;
			buf_valid <= buf_valid_next;
			if (req_done)
				drop <= 1'b0;
			else if (advance && req_wait)
				drop <= 1'b1;   // redirected under an open request
			// address stays put until data_ok
			if (!req_wait) begin
				ireq_valid <= ~buf_valid_next;
				ireq_addr <= pc_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (resp_good && !advance)
			buf_instr <= iresp_data;
		if (advance)
			if_pc <= pc;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			if_valid <= 1'b0;
			if_instr <= nop_instr;
		end else if (advance) begin
			if (flush) begin
				if_valid <= 1'b0;
				if_instr <= nop_instr;
			end else begin
				if_valid <= 1'b1;
				if_instr <= cur_instr;
			end
		end
	end

endmodule

/* decode_stage.sv */
module decode_stage (
	input  logic clk,
	input  logic reset,
	input  logic stall,
	input  logic flush,
	input  logic if_valid,
	input  logic [core_pkg::xlen-1:0] if_pc,
	input  logic [core_pkg::ilen-1:0] if_instr,
	input  logic [core_pkg::xlen-1:0] rs1_data,
	input  logic [core_pkg::xlen-1:0] rs2_data,
	output logic [core_pkg::reg_addr_w-1:0] rs1_addr,
	output logic [core_pkg::reg_addr_w-1:0] rs2_addr,
	output logic id_valid,
	output logic [core_pkg::xlen-1:0] id_pc,
	output logic [core_pkg::reg_addr_w-1:0] id_rs1,
	output logic [core_pkg::reg_addr_w-1:0] id_rs2,
	output logic [core_pkg::xlen-1:0] id_rs1_val,
	output logic [core_pkg::xlen-1:0] id_rs2_val,
	output logic [core_pkg::xlen-1:0] id_imm,
	output logic [core_pkg::reg_addr_w-1:0] id_rd,
	output core_pkg::alu_op_t id_alu_op,
	output logic id_use_imm,
	output logic id_reg_write,
	output logic id_mem_read,
	output logic id_mem_write,
	output logic id_branch,
	output logic id_branch_ne,
	output logic id_jump
);
	import core_pkg::*;

	logic [6:0] opcode, funct7;
	logic [2:0] funct3;
	logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm;
	alu_op_t alu_op;
	logic known, uses_rs1, uses_rs2, keep;
	logic use_imm, reg_write, mem_read, mem_write, branch, branch_ne, jump;

	assign opcode = if_instr[6:0];
	assign funct3 = if_instr[14:12];
	assign funct7 = if_instr[31:25];

	assign imm_i = {{52{if_instr[31]}}, if_instr[31:20]};
	assign imm_s = {{52{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
	assign imm_b = {{51{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
		if_instr[11:8], 1'b0};
	assign imm_u = {{32{if_instr[31]}}, if_instr[31:12], 12'b0};
	assign imm_j = {{43{if_instr[31]}}, if_instr[31], if_instr[19:12], if_instr[20],
		if_instr[30:21], 1'b0};

	always_comb begin
		known = 1'b1;
		uses_rs1 = 1'b1;
		uses_rs2 = 1'b0;
		alu_op = alu_add;
		use_imm = 1'b1;
		imm = imm_i;
		reg_write = 1'b1;
		mem_read = 1'b0;
		mem_write = 1'b0;
		branch = 1'b0;
		branch_ne = 1'b0;
		jump = 1'b0;
		case (opcode)
			op_rtype: begin
				uses_rs2 = 1'b1;
				use_imm = 1'b0;
				case ({funct7, funct3})
					{funct7_base, f3_add}: alu_op = alu_add;
					{funct7_sub, f3_add}:  alu_op = alu_sub;
					{funct7_base, f3_and}: alu_op = alu_and;
					{funct7_base, f3_or}:  alu_op = alu_or;
					{funct7_base, f3_xor}: alu_op = alu_xor;
					default: known = 1'b0;
				endcase
			end
			op_itype: known = (funct3 == f3_add);   // addi only
			op_lui: begin
				uses_rs1 = 1'b0;
				alu_op = alu_pass_b;
				imm = imm_u;
			end
			op_load: begin
				known = (funct3 == f3_dword);
				mem_read = 1'b1;
			end
			op_store: begin
				known = (funct3 == f3_dword);
				uses_rs2 = 1'b1;
				imm = imm_s;
				reg_write = 1'b0;
				mem_write = 1'b1;
			end
			op_branch: begin
				known = (funct3 == f3_beq) || (funct3 == f3_bne);
				uses_rs2 = 1'b1;
				use_imm = 1'b0;
				imm = imm_b;
				reg_write = 1'b0;
				branch = 1'b1;
				branch_ne = (funct3 == f3_bne);
			end
			op_jal: begin
				uses_rs1 = 1'b0;
				imm = imm_j;
				jump = 1'b1;
			end
			default: known = 1'b0;
		endcase
	end

	// unused source fields read x0, so they never look like a hazard
	assign rs1_addr = uses_rs1 ? if_instr[19:15] : '0;
	assign rs2_addr = uses_rs2 ? if_instr[24:20] : '0;
	assign keep = if_valid & known & ~flush;

	always_ff @(posedge clk) begin
		if (reset) begin
			id_valid <= 1'b0;
			id_reg_write <= 1'b0;
			id_mem_read <= 1'b0;
			id_mem_write <= 1'b0;
			id_branch <= 1'b0;
			id_branch_ne <= 1'b0;
			id_jump <= 1'b0;
		end else if (!stall) begin
			id_valid <= keep;
			id_reg_write <= keep & reg_write;
			id_mem_read <= keep & mem_read;
			id_mem_write <= keep & mem_write;
			id_branch <= keep & branch;
			id_branch_ne <= keep & branch_ne;
			id_jump <= keep & jump;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			id_pc <= if_pc;
			id_rs1 <= rs1_addr;
			id_rs2 <= rs2_addr;
			id_rs1_val <= rs1_data;
			id_rs2_val <= rs2_data;
			id_imm <= imm;
			id_rd <= reg_write ? if_instr[11:7] : '0;
			id_alu_op <= alu_op;
			id_use_imm <= use_imm;
		end
	end

endmodule

/* execute_stage.sv */
module execute_stage (
	input  logic clk,
	input  logic reset,
	input  logic stall,
	input  logic flush,
	input  logic id_valid,
	input  logic [core_pkg::xlen-1:0] id_pc,
	input  logic [core_pkg::reg_addr_w-1:0] id_rs1,
	input  logic [core_pkg::reg_addr_w-1:0] id_rs2,
	input  logic [core_pkg::xlen-1:0] id_rs1_val,
	input  logic [core_pkg::xlen-1:0] id_rs2_val,
	input  logic [core_pkg::xlen-1:0] id_imm,
	input  logic [core_pkg::reg_addr_w-1:0] id_rd,
	input  core_pkg::alu_op_t id_alu_op,
	input  logic id_use_imm,
	input  logic id_reg_write,
	input  logic id_mem_read,
	input  logic id_mem_write,
	input  logic id_branch,
	input  logic id_branch_ne,
	input  logic id_jump,
	input  logic wb_reg_write,
	input  logic [core_pkg::reg_addr_w-1:0] wb_rd,
	input  logic [core_pkg::xlen-1:0] wb_data,
	output logic redirect,
	output logic [core_pkg::xlen-1:0] redirect_pc,
	output logic ex_valid,
	output logic [core_pkg::xlen-1:0] ex_pc,
	output logic [core_pkg::reg_addr_w-1:0] ex_rd,
	output logic [core_pkg::xlen-1:0] ex_result,
	output logic [core_pkg::xlen-1:0] ex_store_data,
	output logic ex_reg_write,
	output logic ex_mem_read,
	output logic ex_mem_write
);
	import core_pkg::*;

	logic [xlen-1:0] src_a, src_b, op_b, alu_out, result;
	logic ex_fwd_ok, take;

	// a load in EX/MEM has only its address so far
	assign ex_fwd_ok = ex_reg_write & ~ex_mem_read & (ex_rd != '0);

	always_comb begin
		if (ex_fwd_ok && ex_rd == id_rs1)
			src_a = ex_result;
		else if (wb_reg_write && wb_rd != '0 && wb_rd == id_rs1)
			src_a = wb_data;
		else
			src_a = id_rs1_val;
		if (ex_fwd_ok && ex_rd == id_rs2)
			src_b = ex_result;
		else if (wb_reg_write && wb_rd != '0 && wb_rd == id_rs2)
			src_b = wb_data;
		else
			src_b = id_rs2_val;
	end

	assign op_b = id_use_imm ? id_imm : src_b;

	always_comb begin
		case (id_alu_op)
			alu_sub:    alu_out = src_a - op_b;
			alu_and:    alu_out = src_a & op_b;
			alu_or:     alu_out = src_a | op_b;
			alu_xor:    alu_out = src_a ^ op_b;
			alu_pass_b: alu_out = op_b;
			default:    alu_out = src_a + op_b;
		endcase
	end

	assign result = id_jump ? id_pc + 4 : alu_out;   // jal links pc+4
	assign take = id_jump | (id_branch & ((src_a == src_b) ^ id_branch_ne));
	assign redirect = take;
	assign redirect_pc = id_pc + id_imm;

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_valid <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
		end else if (!stall) begin
			ex_valid <= id_valid & ~flush;
			ex_reg_write <= id_reg_write & ~flush;
			ex_mem_read <= id_mem_read & ~flush;
			ex_mem_write <= id_mem_write & ~flush;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ex_pc <= id_pc;
			ex_rd <= id_rd;
			ex_result <= result;
			ex_store_data <= src_b;
		end
	end

endmodule

/* memory_stage.sv */
module memory_stage (
	input  logic clk,
	input  logic reset,
	input  logic stall,
	input  logic ex_valid,
	input  logic [core_pkg::xlen-1:0] ex_pc,
	input  logic [core_pkg::reg_addr_w-1:0] ex_rd,
	input  logic [core_pkg::xlen-1:0] ex_result,
	input  logic [core_pkg::xlen-1:0] ex_store_data,
	input  logic ex_reg_write,
	input  logic ex_mem_read,
	input  logic ex_mem_write,
	input  logic dresp_data_ok,
	input  logic [core_pkg::xlen-1:0] dresp_rdata,
	output logic dreq_valid,
	output logic dreq_write,
	output logic [core_pkg::xlen-1:0] dreq_addr,
	output logic [core_pkg::xlen-1:0] dreq_wdata,
	output logic mem_busy,
	output logic wb_valid,
	output logic [core_pkg::xlen-1:0] wb_pc,
	output logic [core_pkg::reg_addr_w-1:0] wb_rd,
	output logic [core_pkg::xlen-1:0] wb_data,
	output logic wb_reg_write
);
	import core_pkg::*;

	logic access, done;
	logic [xlen-1:0] load_q, load_val;

	assign access = ex_valid & (ex_mem_read | ex_mem_write);
	assign dreq_valid = access & ~done;   // one request per EX/MEM entry
	assign dreq_write = ex_mem_write;
	assign dreq_addr = ex_result;
	assign dreq_wdata = ex_store_data;
	assign mem_busy = dreq_valid & ~dresp_data_ok;
	assign load_val = done ? load_q : dresp_rdata;

	// data_ok came while the pipe was frozen for fetch
	always_ff @(posedge clk) begin
		if (reset)
			done <= 1'b0;
		else if (!stall)
			done <= 1'b0;
		else if (dreq_valid && dresp_data_ok)
			done <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (dreq_valid && dresp_data_ok)
			load_q <= dresp_rdata;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
			wb_reg_write <= 1'b0;
		end else if (!stall) begin
			wb_valid <= ex_valid;
			wb_reg_write <= ex_valid & ex_reg_write;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			wb_pc <= ex_pc;
			wb_rd <= ex_rd;
			wb_data <= (ex_rd == '0) ? '0 : (ex_mem_read ? load_val : ex_result);
		end
	end

endmodule

/* hazard_unit.sv */
module hazard_unit (
	input  logic fetch_busy,
	input  logic mem_busy,
	input  logic redirect,
	input  logic id_mem_read,
	input  logic [core_pkg::reg_addr_w-1:0] id_rd,
	input  logic [core_pkg::reg_addr_w-1:0] rs1_addr,
	input  logic [core_pkg::reg_addr_w-1:0] rs2_addr,
	output logic stall_if,
	output logic stall_id,
	output logic stall_ex,
	output logic stall_mem,
	output logic flush_if,
	output logic flush_id
);

	logic freeze, load_use;

	assign freeze = fetch_busy | mem_busy;   // either bus waiting
	assign load_use = id_mem_read & (id_rd != '0) & ((id_rd == rs1_addr) | (id_rd == rs2_addr));

	// pc and IF/ID wait one cycle while ID/EX takes the bubble
	assign stall_if = freeze | load_use;
	assign stall_id = freeze;
	assign stall_ex = freeze;
	assign stall_mem = freeze;

	assign flush_if = redirect;
	assign flush_id = redirect | load_use;

endmodule

/* core.sv */
module core (
	input  logic clk,
	input  logic reset,
	output logic ireq_valid,
	output logic [core_pkg::xlen-1:0] ireq_addr,
	input  logic iresp_data_ok,
	input  logic [core_pkg::ilen-1:0] iresp_data,
	output logic dreq_valid,
	output logic dreq_write,
	output logic [core_pkg::xlen-1:0] dreq_addr,
	output logic [core_pkg::xlen-1:0] dreq_wdata,
	input  logic dresp_data_ok,
	input  logic [core_pkg::xlen-1:0] dresp_rdata,
	output logic commit_valid,
	output logic [core_pkg::xlen-1:0] commit_pc,
	output logic commit_wen,
	output logic [core_pkg::reg_addr_w-1:0] commit_rd,
	output logic [core_pkg::xlen-1:0] commit_data
);
	import core_pkg::*;

	logic stall_if, stall_id, stall_ex, stall_mem, flush_if, flush_id;
	logic fetch_busy, mem_busy, redirect;
	logic [xlen-1:0] redirect_pc;

	logic if_valid;
	logic [xlen-1:0] if_pc;
	logic [ilen-1:0] if_instr;

	logic [reg_addr_w-1:0] rs1_addr, rs2_addr;
	logic [xlen-1:0] rs1_data, rs2_data;

	logic id_valid, id_use_imm, id_reg_write, id_mem_read, id_mem_write;
	logic id_branch, id_branch_ne, id_jump;
	logic [xlen-1:0] id_pc, id_rs1_val, id_rs2_val, id_imm;
	logic [reg_addr_w-1:0] id_rs1, id_rs2, id_rd;
	alu_op_t id_alu_op;

	logic ex_valid, ex_reg_write, ex_mem_read, ex_mem_write;
	logic [xlen-1:0] ex_pc, ex_result, ex_store_data;
	logic [reg_addr_w-1:0] ex_rd;

	logic wb_valid, wb_reg_write;
	logic [xlen-1:0] wb_pc, wb_data;
	logic [reg_addr_w-1:0] wb_rd;

	fetch_stage fetch_stage_inst (
		.clk, .reset, .stall(stall_if), .flush(flush_if), .redirect, .redirect_pc,
		.iresp_data_ok, .iresp_data, .ireq_valid, .ireq_addr, .fetch_busy,
		.if_valid, .if_pc, .if_instr
	);

	decode_stage decode_stage_inst (
		.clk, .reset, .stall(stall_id), .flush(flush_id), .if_valid, .if_pc, .if_instr,
		.rs1_data, .rs2_data, .rs1_addr, .rs2_addr, .id_valid, .id_pc, .id_rs1, .id_rs2,
		.id_rs1_val, .id_rs2_val, .id_imm, .id_rd, .id_alu_op, .id_use_imm, .id_reg_write,
		.id_mem_read, .id_mem_write, .id_branch, .id_branch_ne, .id_jump
	);

	// branches resolve here, so EX/MEM never holds a wrong-path instruction
	execute_stage execute_stage_inst (
		.clk, .reset, .stall(stall_ex), .flush(1'b0), .id_valid, .id_pc, .id_rs1, .id_rs2,
		.id_rs1_val, .id_rs2_val, .id_imm, .id_rd, .id_alu_op, .id_use_imm, .id_reg_write,
		.id_mem_read, .id_mem_write, .id_branch, .id_branch_ne, .id_jump,
		.wb_reg_write, .wb_rd, .wb_data, .redirect, .redirect_pc, .ex_valid, .ex_pc,
		.ex_rd, .ex_result, .ex_store_data, .ex_reg_write, .ex_mem_read, .ex_mem_write
	);

	memory_stage memory_stage_inst (
		.clk, .reset, .stall(stall_mem), .ex_valid, .ex_pc, .ex_rd, .ex_result,
		.ex_store_data, .ex_reg_write, .ex_mem_read, .ex_mem_write, .dresp_data_ok,
		.dresp_rdata, .dreq_valid, .dreq_write, .dreq_addr, .dreq_wdata, .mem_busy,
		.wb_valid, .wb_pc, .wb_rd, .wb_data, .wb_reg_write
	);

	regfile regfile_inst (
		.clk, .reset, .rs1_addr, .rs2_addr, .wen(wb_reg_write), .wa(wb_rd), .wd(wb_data),
		.rs1_data, .rs2_data
	);

	hazard_unit hazard_unit_inst (
		.fetch_busy, .mem_busy, .redirect, .id_mem_read, .id_rd, .rs1_addr, .rs2_addr,
		.stall_if, .stall_id, .stall_ex, .stall_mem, .flush_if, .flush_id
	);

	assign commit_valid = wb_valid & ~stall_mem;   // pulses as MEM/WB moves on
	assign commit_pc = wb_pc;
	assign commit_wen = wb_reg_write;
	assign commit_rd = wb_rd;
	assign commit_data = wb_data;

endmodule

/* core_checker.sv */
module core_checker (
	input  logic clk,
	input  logic reset,
	input  logic ireq_valid,
	input  logic [core_pkg::xlen-1:0] ireq_addr,
	input  logic iresp_data_ok,
	input  logic dreq_valid,
	input  logic dreq_write,
	input  logic [core_pkg::xlen-1:0] dreq_addr,
	input  logic [core_pkg::xlen-1:0] dreq_wdata,
	input  logic dresp_data_ok,
	input  logic commit_valid,
	input  logic [core_pkg::xlen-1:0] commit_pc,
	input  logic commit_wen,
	input  logic [core_pkg::reg_addr_w-1:0] commit_rd,
	input  logic [core_pkg::xlen-1:0] commit_data,
	input  logic redirect,
	input  logic stall_ex,
	input  logic if_valid,
	input  logic id_valid,
	input  logic exp_valid,
	input  logic [core_pkg::xlen-1:0] exp_pc,
	input  logic exp_wen,
	input  logic [core_pkg::reg_addr_w-1:0] exp_rd,
	input  logic [core_pkg::xlen-1:0] exp_data
);
	timeunit 1ns;
	timeprecision 1ps;
	import core_pkg::*;

	int error_count = 0;

	reset_state: assert property (@(posedge clk)
		$fell(reset) |-> !ireq_valid && !dreq_valid && !commit_valid
			##1 ireq_valid && ireq_addr == reset_pc)
		else begin
			$error("bus or commit outputs wrong after reset, or first fetch not at reset pc");
			error_count++;
		end

	ireq_hold: assert property (@(posedge clk) disable iff (reset)
		ireq_valid && !iresp_data_ok |=> ireq_valid && $stable(ireq_addr))
		else begin
			$error("instruction request dropped or changed before data_ok");
			error_count++;
		end

	dreq_hold: assert property (@(posedge clk) disable iff (reset)
		dreq_valid && !dresp_data_ok |=> dreq_valid && $stable(dreq_addr)
			&& $stable(dreq_write) && $stable(dreq_wdata))
		else begin
			$error("data request dropped or changed before data_ok");
			error_count++;
		end

	commit_pc_match: assert property (@(posedge clk) disable iff (reset)
		commit_valid && exp_valid |-> commit_pc == exp_pc)
		else begin
			$error("error commit_pc got %h expected %h", $sampled(commit_pc), $sampled(exp_pc));
			error_count++;
		end

	commit_rd_match: assert property (@(posedge clk) disable iff (reset)
		commit_valid && exp_valid |-> commit_wen == exp_wen && commit_rd == exp_rd)
		else begin
			$error("error commit_rd got %h expected %h, commit_wen got %h expected %h",
				$sampled(commit_rd), $sampled(exp_rd), $sampled(commit_wen), $sampled(exp_wen));
			error_count++;
		end

	commit_data_match: assert property (@(posedge clk) disable iff (reset)
		commit_valid && exp_valid |-> commit_data == exp_data)
		else begin
			$error("error commit_data got %h expected %h",
				$sampled(commit_data), $sampled(exp_data));
			error_count++;
		end

	flush_younger: assert property (@(posedge clk) disable iff (reset)
		redirect && !stall_ex |=> !if_valid && !id_valid)
		else begin
			$error("younger stages were not flushed after a taken branch or jump");
			error_count++;
		end

endmodule

/* tb_core.sv */
module tb_core;
	timeunit 1ns;
	timeprecision 1ps;
	import core_pkg::*;

	localparam int prog_len = 26;
	localparam int watchdog_cycles = 40 * prog_len * 4;
	localparam logic [ilen-1:0] spin_instr = 32'h0000_006f;   // jal x0, 0

	logic clk, reset;
	logic ireq_valid, iresp_data_ok;
	logic [xlen-1:0] ireq_addr;
	logic [ilen-1:0] iresp_data;
	logic dreq_valid, dreq_write, dresp_data_ok;
	logic [xlen-1:0] dreq_addr, dreq_wdata, dresp_rdata;
	logic commit_valid, commit_wen;
	logic [xlen-1:0] commit_pc, commit_data;
	logic [reg_addr_w-1:0] commit_rd;

	logic [ilen-1:0] rom [prog_len];
	logic [xlen-1:0] ram [64];
	logic [xlen-1:0] exp_pc_tab [32], exp_data_tab [32];
	logic [reg_addr_w-1:0] exp_rd_tab [32];
	logic exp_wen_tab [32];
	int exp_count = 0;
	int commit_idx = 0;
	int unsigned lcg_state = 19;
	int i_left, d_left;
	bit i_pending, d_pending;

	logic exp_valid, exp_wen;
	logic [xlen-1:0] exp_pc, exp_data;
	logic [reg_addr_w-1:0] exp_rd;

	assign exp_valid = (commit_idx < exp_count);
	assign exp_pc = exp_pc_tab[commit_idx];
	assign exp_wen = exp_wen_tab[commit_idx];
	assign exp_rd = exp_rd_tab[commit_idx];
	assign exp_data = exp_data_tab[commit_idx];

	core core_inst (.*);

	bind core core_checker core_checker_inst (.*,
		.exp_valid(tb_core.exp_valid), .exp_pc(tb_core.exp_pc), .exp_wen(tb_core.exp_wen),
		.exp_rd(tb_core.exp_rd), .exp_data(tb_core.exp_data));

	function automatic int unsigned next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic int draw_latency();
		return (next_random() >> 16) % 4;   // 0 to 3 wait cycles
	endfunction

	function automatic logic [ilen-1:0] fetch_word(input logic [xlen-1:0] addr);
		if ((addr >> 2) < prog_len)
			return rom[addr >> 2];
		return spin_instr;
	endfunction

	task automatic add_expected(input logic [xlen-1:0] pc, input logic wen,
		input logic [reg_addr_w-1:0] rd, input logic [xlen-1:0] data);
		exp_pc_tab[exp_count] = pc;
		exp_wen_tab[exp_count] = wen;
		exp_rd_tab[exp_count] = rd;
		exp_data_tab[exp_count] = data;
		exp_count++;
	endtask

	task automatic finish_run(input bit timed_out);
		int check_errors;
		check_errors = core_inst.core_checker_inst.error_count;
		$display("summary: assertion errors %0d, commits %0d of %0d, timeouts %0d",
			check_errors, commit_idx, exp_count, timed_out);
		if (check_errors == 0 && !timed_out && commit_idx == exp_count)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		rom = '{
			32'h12300093, 32'h45608113,   // addi x1 x0 0x123; addi x2 x1 0x456
			32'h002081b3, 32'h40118233,   // add x3 x1 x2; sub x4 x3 x1
			32'h0021f2b3, 32'h0012e333,   // and x5 x3 x2; or x6 x5 x1
			32'h004343b3, 32'h80000437,   // xor x7 x6 x4; lui x8 0x80000
			32'h007404b3, 32'h40100533,   // add x9 x8 x7; sub x10 x0 x1
			32'h00903823, 32'h01003583,   // sd x9 16(x0); ld x11 16(x0)
			32'h00158633, 32'h00108013,   // add x12 x11 x1 (load-use); addi x0 x1 1
			32'h00003423, 32'h00803683,   // sd x0 8(x0); ld x13 8(x0)
			32'h00220663, 32'h00100713,   // beq x4 x2 +12 (taken); skipped
			32'h00200713, 32'h00109463,   // skipped; bne x1 x1 +8 (not taken)
			32'h07700793, 32'h00c0086f,   // addi x15 x0 0x77; jal x16 +12
			32'h00100793, 32'h00200793,   // skipped; skipped
			32'h00f808b3, spin_instr      // add x17 x16 x15; spin
		};
		for (int i = 0; i < 64; i++)
			ram[i] = 64'h5a5a_0000_0000_0000 | (64'(i) << 16) | 64'(i);
		add_expected(64'h00, 1'b1, 5'd1, 64'h123);
		add_expected(64'h04, 1'b1, 5'd2, 64'h579);
		add_expected(64'h08, 1'b1, 5'd3, 64'h69c);
		add_expected(64'h0c, 1'b1, 5'd4, 64'h579);
		add_expected(64'h10, 1'b1, 5'd5, 64'h418);
		add_expected(64'h14, 1'b1, 5'd6, 64'h53b);
		add_expected(64'h18, 1'b1, 5'd7, 64'h042);
		add_expected(64'h1c, 1'b1, 5'd8, 64'hffff_ffff_8000_0000);
		add_expected(64'h20, 1'b1, 5'd9, 64'hffff_ffff_8000_0042);
		add_expected(64'h24, 1'b1, 5'd10, 64'hffff_ffff_ffff_fedd);
		add_expected(64'h28, 1'b0, 5'd0, 64'h0);
		add_expected(64'h2c, 1'b1, 5'd11, 64'hffff_ffff_8000_0042);
		add_expected(64'h30, 1'b1, 5'd12, 64'hffff_ffff_8000_0165);
		add_expected(64'h34, 1'b1, 5'd0, 64'h0);
		add_expected(64'h38, 1'b0, 5'd0, 64'h0);
		add_expected(64'h3c, 1'b1, 5'd13, 64'h0);   // reads back the stored x0
		add_expected(64'h40, 1'b0, 5'd0, 64'h0);
		add_expected(64'h4c, 1'b0, 5'd0, 64'h0);
		add_expected(64'h50, 1'b1, 5'd15, 64'h77);
		add_expected(64'h54, 1'b1, 5'd16, 64'h58);
		add_expected(64'h60, 1'b1, 5'd17, 64'hcf);
	end

	initial begin
		reset = 1'b1;
		iresp_data_ok = 1'b0;
		iresp_data = '0;
		dresp_data_ok = 1'b0;
		dresp_rdata = '0;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		while (commit_idx < exp_count)
			@(negedge clk);
		finish_run(1'b0);
	end

	// both buses in one process so the random sequence has a fixed order
	always @(negedge clk) begin
		iresp_data_ok = 1'b0;
		dresp_data_ok = 1'b0;
		if (!reset && ireq_valid) begin
			if (!i_pending) begin
				i_left = draw_latency();
				i_pending = 1'b1;
			end
			if (i_left == 0) begin
				iresp_data_ok = 1'b1;
				iresp_data = fetch_word(ireq_addr);
				i_pending = 1'b0;
			end else begin
				i_left--;
			end
		end
		if (!reset && dreq_valid) begin
			if (!d_pending) begin
				d_left = draw_latency();
				d_pending = 1'b1;
			end
			if (d_left == 0) begin
				dresp_data_ok = 1'b1;
				if (dreq_write)
					ram[dreq_addr[8:3]] = dreq_wdata;
				else
					dresp_rdata = ram[dreq_addr[8:3]];
				d_pending = 1'b0;
			end else begin
				d_left--;
			end
		end
	end

	always @(posedge clk) begin
		if (reset)
			commit_idx <= 0;
		else if (commit_valid)
			commit_idx <= commit_idx + 1;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout: the program did not finish within %0d cycles", watchdog_cycles);
		finish_run(1'b1);
	end

endmodule

/* vlog.f */
core_pkg.sv
regfile.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
core.sv
core_checker.sv
tb_core.sv

/* Bender.yml */
package:
  name: core

sources:
  - core_pkg.sv
  - regfile.sv
  - fetch_stage.sv
  - decode_stage.sv
  - execute_stage.sv
  - memory_stage.sv
  - hazard_unit.sv
  - core.sv
  - target: test
    files:
      - core_checker.sv
      - tb_core.sv
